// ==== vlog.f ====
common/zx_pkg.sv
clocking/ce_divider.sv
clocking/turbo_ctrl.sv
paging/page_regs.sv
paging/addr_map.sv
src/zx_mem_core.sv
dv/zx_mem_core_props.sv
dv/tb_zx_mem_core.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the core testbench
# The run passes only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

# Assertion errors keep the run going so the closing summary is printed
verilator --binary --timing --assert --top-module tb_zx_mem_core -f vlog.f \
	&& ./obj_dir/Vtb_zx_mem_core +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "build or simulation ended abnormally"

cat sim.log 2>/dev/null
grep -qx "TEST PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// ==== dv/tb_zx_mem_core.sv ====
/*
 * Table-driven testbench for the clocking and paging core
 * Clock, reset, stimulus table, LFSR data, compare tasks and cycle timeout
 */
`timescale 1ns/10ps
`default_nettype none

module tb_zx_mem_core import zx_pkg::*; ();

	typedef enum logic [2:0] {
		op_port,
		op_rd,
		op_wr,
		op_speed,
		op_pause,
		op_ready
	} op_t;

	// Where the expected bank of an access comes from
	typedef enum logic [1:0] {
		src_tab,
		src_ram,
		src_rom
	} bank_src_t;

	typedef struct packed {
		machine_t          machine;
		op_t               op;
		logic [15:0]       addr;
		logic [7:0]        data;
		logic              rnd;
		bank_src_t         src;
		logic [BANK_W-1:0] bank;
		logic              we;
		logic              rd;
		logic [5:0]        period;
	} row_t;

	logic               clk_sys = 1'b0;
	logic               reset;
	machine_t           machine;
	logic [SPEED_W-1:0] speed;
	logic               pause;
	logic               ram_ready;
	cpu_bus_t           bus;
	logic               ce_cpu_p;
	logic               ce_cpu_n;
	logic               cpu_en;
	mem_req_t           mem;

	row_t       rows[$];
	machine_t   cur_machine;
	int         cur_period = 32;
	logic [7:0] rand_page = '0;
	logic [7:0] lfsr;
	int         mem_errors = 0;
	int         period_errors = 0;
	int         cycles = 0;
	int         cycle_limit = 0;

	zx_mem_core u_dut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.machine   (machine),
		.speed     (speed),
		.pause     (pause),
		.ram_ready (ram_ready),
		.bus       (bus),
		.ce_cpu_p  (ce_cpu_p),
		.ce_cpu_n  (ce_cpu_n),
		.cpu_en    (cpu_en),
		.mem       (mem)
	);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ==================================================
	// Random data from a right-shifting Galois LFSR
	// ==================================================
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {1'b0, s[7:1]} ^ (s[0] ? 8'hB8 : 8'h00);
	endfunction

	task automatic random_byte(output logic [7:0] b);
		int i;
		b = '0;
		for (i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic check_mem(input string what, input mem_req_t got, input mem_req_t exp);
		if (got !== exp) begin
			mem_errors++;
			$display("error %0t: %s mem addr/din/we/rd %h/%h/%b/%b, expected %h/%h/%b/%b",
				$time, what, got.addr, got.din, got.we, got.rd,
				exp.addr, exp.din, exp.we, exp.rd);
		end
	endtask

	task automatic check_period(input string what, input int got, input int exp);
		if (got != exp) begin
			period_errors++;
			$display("error %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
		end
	endtask

	// ==================================================
	// Stimulus and measurement
	// ==================================================
	task automatic add_row(input machine_t m, input op_t op, input logic [15:0] addr,
		input logic [7:0] data, input logic rnd, input bank_src_t src,
		input logic [BANK_W-1:0] bank, input logic we, input logic rd,
		input logic [5:0] period);
		row_t r;
		r.machine = m;
		r.op      = op;
		r.addr    = addr;
		r.data    = data;
		r.rnd     = rnd;
		r.src     = src;
		r.bank    = bank;
		r.we      = we;
		r.rd      = rd;
		r.period  = period;
		rows.push_back(r);
	endtask

	task automatic apply_reset(input machine_t m);
		@(posedge clk_sys);
		reset   <= 1'b1;
		machine <= m;
		speed   <= '0;
		pause   <= 1'b0;
		bus     <= '0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		cur_machine = m;
		cur_period  = 32;
	endtask

	task automatic wait_level(input logic lvl);
		@(negedge clk_sys);
		while (cpu_en !== lvl) @(negedge clk_sys);
	endtask

	// Positive enable to positive enable with the negative phase in between
	task automatic measure_period(input int exp);
		int  n_full;
		int  n_half;
		logic done;
		n_full = 0;
		n_half = 0;
		done   = 1'b0;
		while (!ce_cpu_p) @(negedge clk_sys);
		while (!done) begin
			@(negedge clk_sys);
			n_full++;
			if (ce_cpu_n && n_half == 0) n_half = n_full;
			if (ce_cpu_p) done = 1'b1;
		end
		check_period("ce_cpu_p period", n_full, exp);
		check_period("ce_cpu_n offset", n_half, exp / 2);
	endtask

	task automatic count_enables(input int window, output int n);
		int i;
		n = 0;
		for (i = 0; i < window; i++) begin
			@(negedge clk_sys);
			if (ce_cpu_p || ce_cpu_n) n++;
		end
	endtask

	task automatic port_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_bus_t b;
		b      = '0;
		b.addr = addr;
		b.dout = data;
		b.iorq = 1'b1;
		b.wr   = 1'b1;
		@(posedge clk_sys);
		bus <= b;
		repeat (2) @(posedge clk_sys);
		bus <= '0;
		@(posedge clk_sys);
	endtask

	function automatic logic [BANK_W-1:0] expected_bank(input row_t r, input logic [7:0] page);
		case (r.src)
			src_ram: return {4'd0, page[2:0]};
			// 128K ROM page is 0, 1, 1, bit 4
			src_rom: return {ROM_REGION, 3'b011, page[4]};
			default: return r.bank;
		endcase
	endfunction

	// One cycle from bus to the registered request
	task automatic mem_access(input int idx, input row_t r, input logic [7:0] data);
		cpu_bus_t b;
		mem_req_t exp;
		b        = '0;
		b.addr   = r.addr;
		b.dout   = data;
		b.mreq   = 1'b1;
		b.rd     = (r.op == op_rd);
		b.wr     = (r.op == op_wr);
		exp.addr = {expected_bank(r, rand_page), r.addr[OFFS_W-1:0]};
		exp.din  = data;
		exp.we   = r.we;
		exp.rd   = r.rd;
		@(posedge clk_sys);
		bus <= b;
		@(posedge clk_sys);
		bus <= '0;
		@(negedge clk_sys);
		check_mem($sformatf("row %0d at %h", idx, r.addr), mem, exp);
	endtask

	task automatic apply_row(input int idx, input row_t r);
		logic [7:0] data;
		int         n;
		string      what;
		data = r.data;
		case (r.op)
			op_port: begin
				if (r.rnd) begin
					random_byte(data);
					// Keep paging unlocked
					data[5]   = 1'b0;
					rand_page = data;
				end
				port_write(r.addr, data);
			end
			op_rd, op_wr: begin
				if (r.rnd) random_byte(data);
				mem_access(idx, r, data);
			end
			op_speed: begin
				@(posedge clk_sys);
				speed <= r.data[SPEED_W-1:0];
				if (int'(r.period) != cur_period) wait_level(1'b0);
				wait_level(1'b1);
				measure_period(int'(r.period));
				cur_period = int'(r.period);
			end
			default: begin
				// Pause and RAM back-pressure both stop the CPU
				@(posedge clk_sys);
				if (r.op == op_pause) begin
					pause <= 1'b1;
					what  = "enable pulses while paused";
				end else begin
					ram_ready <= 1'b0;
					what      = "enable pulses while RAM not ready";
				end
				wait_level(1'b0);
				count_enables(4 * cur_period, n);
				check_period(what, n, 0);
				@(posedge clk_sys);
				pause     <= 1'b0;
				ram_ready <= 1'b1;
				wait_level(1'b1);
				measure_period(int'(r.period));
			end
		endcase
	endtask

	task automatic fill_table();
		// 128K speeds, pause, RAM wait at x16 and paging with random 7FFD data
		add_row(m_128, op_speed, 16'h0000, 8'd0, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd32);
		add_row(m_128, op_speed, 16'h0000, 8'd1, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd16);
		add_row(m_128, op_speed, 16'h0000, 8'd2, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd8);
		add_row(m_128, op_speed, 16'h0000, 8'd3, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd4);
		add_row(m_128, op_speed, 16'h0000, 8'd4, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd2);
		add_row(m_128, op_pause, 16'h0000, 8'd0, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd2);
		add_row(m_128, op_ready, 16'h0000, 8'd0, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd2);
		add_row(m_128, op_rd,    16'h0123, 8'h00, 1'b0, src_tab, 7'h56, 1'b0, 1'b1, 6'd0);
		add_row(m_128, op_port,  16'h7FFD, 8'h00, 1'b1, src_tab, 7'h00, 1'b0, 1'b0, 6'd0);
		add_row(m_128, op_rd,    16'hC234, 8'h00, 1'b0, src_ram, 7'h00, 1'b0, 1'b1, 6'd0);
		add_row(m_128, op_wr,    16'hC010, 8'h00, 1'b1, src_ram, 7'h00, 1'b1, 1'b0, 6'd0);
		add_row(m_128, op_rd,    16'h0100, 8'h00, 1'b0, src_rom, 7'h00, 1'b0, 1'b1, 6'd0);
		add_row(m_128, op_wr,    16'h0000, 8'h5A, 1'b0, src_rom, 7'h00, 1'b0, 1'b0, 6'd0);
		add_row(m_128, op_rd,    16'h4001, 8'h00, 1'b0, src_tab, 7'h05, 1'b0, 1'b1, 6'd0);
		add_row(m_128, op_wr,    16'h8002, 8'h3C, 1'b0, src_tab, 7'h02, 1'b1, 1'b0, 6'd0);
		add_row(m_128, op_port,  16'h7FFD, 8'h23, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd0);
		add_row(m_128, op_port,  16'h7FFD, 8'h06, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd0);
		add_row(m_128, op_rd,    16'hC000, 8'h00, 1'b0, src_tab, 7'h03, 1'b0, 1'b1, 6'd0);
		add_row(m_128, op_rd,    16'h0000, 8'h00, 1'b0, src_tab, 7'h56, 1'b0, 1'b1, 6'd0);
		// +3 normal ROM paging and then all-RAM configs
		add_row(m_plus3, op_rd,   16'h0000, 8'h00, 1'b0, src_tab, 7'h58, 1'b0, 1'b1, 6'd0);
		add_row(m_plus3, op_port, 16'h7FFD, 8'h10, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd0);
		add_row(m_plus3, op_rd,   16'h0000, 8'h00, 1'b0, src_tab, 7'h59, 1'b0, 1'b1, 6'd0);
		add_row(m_plus3, op_port, 16'h1FFD, 8'h04, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd0);
		add_row(m_plus3, op_rd,   16'h0010, 8'h00, 1'b0, src_tab, 7'h5B, 1'b0, 1'b1, 6'd0);
		add_row(m_plus3, op_wr,   16'h0000, 8'h77, 1'b0, src_tab, 7'h5B, 1'b0, 1'b0, 6'd0);
		add_row(m_plus3, op_port, 16'h1FFD, 8'h07, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd0);
		add_row(m_plus3, op_rd,   16'h0000, 8'h00, 1'b0, src_tab, 7'h04, 1'b0, 1'b1, 6'd0);
		add_row(m_plus3, op_rd,   16'h4000, 8'h00, 1'b0, src_tab, 7'h07, 1'b0, 1'b1, 6'd0);
		add_row(m_plus3, op_rd,   16'h8000, 8'h00, 1'b0, src_tab, 7'h06, 1'b0, 1'b1, 6'd0);
		add_row(m_plus3, op_rd,   16'hC000, 8'h00, 1'b0, src_tab, 7'h03, 1'b0, 1'b1, 6'd0);
		add_row(m_plus3, op_wr,   16'h0005, 8'h00, 1'b1, src_tab, 7'h04, 1'b1, 1'b0, 6'd0);
		add_row(m_plus3, op_port, 16'h1FFD, 8'h03, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd0);
		add_row(m_plus3, op_rd,   16'hC000, 8'h00, 1'b0, src_tab, 7'h07, 1'b0, 1'b1, 6'd0);
		add_row(m_plus3, op_rd,   16'h4000, 8'h00, 1'b0, src_tab, 7'h05, 1'b0, 1'b1, 6'd0);
		add_row(m_plus3, op_port, 16'h1FFD, 8'h01, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd0);
		add_row(m_plus3, op_rd,   16'h0000, 8'h00, 1'b0, src_tab, 7'h00, 1'b0, 1'b1, 6'd0);
		add_row(m_plus3, op_port, 16'h1FFD, 8'h05, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd0);
		add_row(m_plus3, op_rd,   16'hC000, 8'h00, 1'b0, src_tab, 7'h03, 1'b0, 1'b1, 6'd0);
		add_row(m_plus3, op_speed, 16'h0000, 8'd4, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd2);
		add_row(m_plus3, op_speed, 16'h0000, 8'd7, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd32);
		// 48K ignores 7FFD
		add_row(m_48, op_port, 16'h7FFD, 8'h07, 1'b0, src_tab, 7'h00, 1'b0, 1'b0, 6'd0);
		add_row(m_48, op_rd,   16'hC000, 8'h00, 1'b0, src_tab, 7'h00, 1'b0, 1'b1, 6'd0);
		add_row(m_48, op_rd,   16'h0000, 8'h00, 1'b0, src_tab, 7'h5F, 1'b0, 1'b1, 6'd0);
		add_row(m_48, op_wr,   16'h0000, 8'h99, 1'b0, src_tab, 7'h5F, 1'b0, 1'b0, 6'd0);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int i;
		int prop_errors;
		reset     = 1'b1;
		machine   = m_128;
		speed     = '0;
		pause     = 1'b0;
		ram_ready = 1'b1;
		bus       = '0;
		lfsr      = 8'd85;
		fill_table();
		cycle_limit = rows.size() * 200;
		apply_reset(rows[0].machine);
		for (i = 0; i < rows.size(); i++) begin
			if (rows[i].machine != cur_machine) apply_reset(rows[i].machine);
			apply_row(i, rows[i]);
		end
		repeat (4) @(posedge clk_sys);
		prop_errors = u_dut.u_props.prop_errors;
		$display("errors: mem %0d, period %0d, assertion %0d",
			mem_errors, period_errors, prop_errors);
		if (mem_errors + period_errors + prop_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/zx_mem_core_props.sv ====
/*
 * Concurrent checks on the CPU enables and memory strobes,
 * bound into the core top level
 */
`timescale 1ns/10ps
`default_nettype none

module zx_mem_core_props import zx_pkg::*; (
	input logic     clk_sys,
	input logic     reset,
	input logic     pause,
	input logic     ce_cpu_p,
	input logic     ce_cpu_n,
	input logic     cpu_en,
	input mem_req_t mem
);

	int prop_errors = 0;

	// Phases sit half a period apart
	ce_phases_apart: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_cpu_p && ce_cpu_n))
		else begin
			$error("positive and negative CPU enables high in the same cycle");
			prop_errors++;
		end

	// Negative phase taken with pause high stops the CPU
	pause_stops_cpu: assert property (@(posedge clk_sys) disable iff (reset)
		(ce_cpu_n && pause) |=> !cpu_en)
		else begin
			$error("cpu_en still high after a negative enable with pause set");
			prop_errors++;
		end

	mem_one_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		!(mem.we && mem.rd))
		else begin
			$error("memory write and read strobes high together");
			prop_errors++;
		end

endmodule

bind zx_mem_core zx_mem_core_props u_props (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.pause    (pause),
	.ce_cpu_p (ce_cpu_p),
	.ce_cpu_n (ce_cpu_n),
	.cpu_en   (cpu_en),
	.mem      (mem)
);

`default_nettype wire

// ==== src/zx_mem_core.sv ====
/*
 * Top level of the CPU clocking and memory paging core
 */
`timescale 1ns/10ps
`default_nettype none

module zx_mem_core import zx_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  machine_t           machine,
	input  logic [SPEED_W-1:0] speed,
	input  logic               pause,
	input  logic               ram_ready,
	input  cpu_bus_t           bus,
	output logic               ce_cpu_p,
	output logic               ce_cpu_n,
	output logic               cpu_en,
	output mem_req_t           mem
);

	logic [TURBO_W-1:0] turbo;
	logic               raw_p;
	logic               raw_n;
	page_state_t        state;

	// ==================================================
	// Clocking
	// ==================================================
	ce_divider u_ce_divider (
		.clk_sys (clk_sys),
		.reset   (reset),
		.turbo   (turbo),
		.raw_p   (raw_p),
		.raw_n   (raw_n)
	);

	turbo_ctrl u_turbo_ctrl (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.speed     (speed),
		.pause     (pause),
		.ram_ready (ram_ready),
		.raw_n     (raw_n),
		.raw_p     (raw_p),
		.turbo     (turbo),
		.cpu_en    (cpu_en),
		.ce_cpu_p  (ce_cpu_p),
		.ce_cpu_n  (ce_cpu_n)
	);

	// ==================================================
	// Paging
	// ==================================================
	page_regs u_page_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.machine (machine),
		.bus     (bus),
		.state   (state)
	);

	addr_map u_addr_map (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.state   (state),
		.mem     (mem)
	);

endmodule

`default_nettype wire

// ==== paging/addr_map.sv ====
/*
 * CPU address to RAM address mapping
 * ROM page select, special all-RAM modes and ROM write protection
 */
`timescale 1ns/10ps
`default_nettype none

module addr_map import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  cpu_bus_t    bus,
	input  page_state_t state,
	output mem_req_t    mem
);

	logic [3:0]        page_rom;
	logic [BANK_W-1:0] bank;
	logic [1:0]        cfg;
	logic              special;
	logic              is_rom;
	logic              ram_we;
	logic              ram_rd;

	assign special = state.page_1ffd.spec.special;
	assign cfg     = state.page_1ffd.spec.config_mode;

	always_comb begin
		if (state.plus3) begin
			page_rom = {2'b10, state.page_1ffd.norm.rom_hi, state.page_7ffd[4]};
		end else begin
			page_rom = {state.zx48, 2'b11, state.zx48 | state.page_7ffd[4]};
		end
	end

	// ==================================================
	// Quadrant to bank
	// ==================================================
	always_comb begin
		is_rom = 1'b0;
		if (special) begin
			// 0,1,2,3 / 4,5,6,7 / 4,5,6,3 / 4,7,6,3
			case (bus.addr[15:14])
				2'd0:    bank = {4'd0, |cfg, 2'b00};
				2'd1:    bank = {4'd0, |cfg, &cfg, 1'b1};
				2'd2:    bank = {4'd0, |cfg, 2'b10};
				default: bank = {4'd0, ~cfg[1] & cfg[0], 2'b11};
			endcase
		end else begin
			case (bus.addr[15:14])
				2'd0: begin
					bank   = {ROM_REGION, page_rom};
					is_rom = 1'b1;
				end
				2'd1:    bank = 7'd5;
				2'd2:    bank = 7'd2;
				default: bank = {4'd0, state.page_7ffd[2:0]};
			endcase
		end
	end

	// No writes reach the ROM pages
	assign ram_we = bus.mreq & bus.wr & ~is_rom;
	assign ram_rd = bus.mreq & bus.rd;

	always_ff @(posedge clk_sys) begin
		mem.addr <= {bank, bus.addr[OFFS_W-1:0]};
		mem.din  <= bus.dout;
		if (reset) begin
			mem.we <= 1'b0;
			mem.rd <= 1'b0;
		end else begin
			mem.we <= ram_we;
			mem.rd <= ram_rd;
		end
	end

endmodule

`default_nettype wire

// ==== paging/page_regs.sv ====
/*
 * Paging port decode and the 7FFD / 1FFD registers
 * Machine type flags are captured during reset
 */
`timescale 1ns/10ps
`default_nettype none

module page_regs import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  machine_t    machine,
	input  cpu_bus_t    bus,
	output page_state_t state
);

	logic [7:0] page_7ffd;
	page_1ffd_u page_1ffd;
	logic       zx48;
	logic       plus3;
	logic       page_disable;
	logic       io_wr;
	logic       old_wr;
	logic       wr_edge;
	logic       write_7ffd;
	logic       write_1ffd;

	assign io_wr   = bus.iorq & bus.wr;
	assign wr_edge = io_wr & ~old_wr;

	// Bit 5 of 7FFD locks paging until the next reset
	assign page_disable = zx48 | page_7ffd[5];

	// ==================================================
	// Port decode
	// ==================================================
	// 7FFD, partial decode, A14 only checked on +3
	assign write_7ffd = ~bus.addr[15] & ~bus.addr[1]
		& (bus.addr[14] | ~plus3) & ~page_disable;

	// 1FFD exists on +3 only
	assign write_1ffd = ~bus.addr[1] & bus.addr[12]
		& ~bus.addr[13] & ~bus.addr[14] & ~bus.addr[15]
		& plus3 & ~page_disable;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_wr <= 1'b0;
		end else begin
			old_wr <= io_wr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_7ffd <= '0;
			page_1ffd <= '0;
			zx48      <= (machine == m_48);
			plus3     <= (machine == m_plus3);
		end else if (wr_edge) begin
			if (write_7ffd) begin
				page_7ffd <= bus.dout;
			end else if (write_1ffd) begin
				page_1ffd <= bus.dout;
			end
		end
	end

	// State bundle for the address mapper
	always_comb begin
		state.page_7ffd    = page_7ffd;
		state.page_1ffd    = page_1ffd;
		state.zx48         = zx48;
		state.plus3        = plus3;
		state.page_disable = page_disable;
	end

endmodule

`default_nettype wire

// ==== clocking/turbo_ctrl.sv ====
/*
 * CPU speed selection and run/stop control
 * Speed code decode, mask switching with a settle wait, enable gating
 */
`timescale 1ns/10ps
`default_nettype none

module turbo_ctrl import zx_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic [SPEED_W-1:0] speed,
	input  logic               pause,
	input  logic               ram_ready,
	input  logic               raw_n,
	input  logic               raw_p,
	output logic [TURBO_W-1:0] turbo,
	output logic               cpu_en,
	output logic               ce_cpu_p,
	output logic               ce_cpu_n
);

	logic [TURBO_W-1:0] turbo_req;
	logic [1:0]         fsm;
	logic [1:0]         wait_cnt;
	logic               fast;

	always_comb begin
		case (speed)
			3'd1:    turbo_req = TURBO_X2;
			3'd2:    turbo_req = TURBO_X4;
			3'd3:    turbo_req = TURBO_X8;
			3'd4:    turbo_req = TURBO_X16;
			default: turbo_req = TURBO_ORIG;
		endcase
	end

	// x8 and x16 outrun the RAM and must wait for it
	assign fast = ~|turbo[TURBO_W-1:2];

	// ==================================================
	// Run/stop FSM, stepped on negative phases only
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			turbo    <= TURBO_ORIG;
			fsm      <= ST_SWITCHING;
			wait_cnt <= '0;
			cpu_en   <= 1'b0;
		end else if (raw_n) begin
			if (turbo_req != turbo) begin
				turbo    <= turbo_req;
				fsm      <= ST_SWITCHING;
				wait_cnt <= '0;
				cpu_en   <= 1'b0;
			end else begin
				case (fsm)
					ST_SWITCHING: begin
						if (wait_cnt != 2'(SWITCH_WAIT - 1)) begin
							wait_cnt <= wait_cnt + 2'd1;
						end else if (ram_ready) begin
							cpu_en <= ~pause;
							fsm    <= pause ? ST_STOPPED : ST_RUNNING;
						end
					end
					ST_RUNNING: begin
						if ((fast & ~ram_ready) | pause) begin
							cpu_en <= 1'b0;
							fsm    <= ST_STOPPED;
						end
					end
					ST_STOPPED: begin
						if (ram_ready & ~pause) begin
							cpu_en <= 1'b1;
							fsm    <= ST_RUNNING;
						end
					end
					default: begin
						cpu_en <= 1'b0;
						fsm    <= ST_STOPPED;
					end
				endcase
			end
		end
	end

	// Enables reach the CPU only while it runs
	assign ce_cpu_p = cpu_en & raw_p;
	assign ce_cpu_n = cpu_en & raw_n;

endmodule

`default_nettype wire

// ==== clocking/ce_divider.sv ====
/*
 * Free-running divider for the raw CPU clock-enable phases
 */
`timescale 1ns/10ps
`default_nettype none

module ce_divider import zx_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic [TURBO_W-1:0] turbo,
	output logic               raw_p,
	output logic               raw_n
);

	logic [5:0]         counter;
	logic [TURBO_W-1:0] masked;
	logic [TURBO_W-1:0] half_point;

	// Counter bits that matter at the current speed
	assign masked = counter[TURBO_W-1:0] & turbo;

	// Top bit under the mask, which sits half a period away from zero
	assign half_point = turbo ^ {1'b0, turbo[TURBO_W-1:1]};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			raw_p   <= 1'b0;
			raw_n   <= 1'b0;
		end else begin
			counter <= counter + 6'd1;
			raw_p   <= (masked == '0);
			raw_n   <= (masked == half_point);
		end
	end

endmodule

`default_nettype wire

// ==== common/zx_pkg.sv ====
/*
 * Shared definitions for the CPU clocking and paging core:
 * widths, turbo masks, FSM encodings, CPU bus and memory request structs,
 * the 1FFD register union and the paging state bundle
 */
`default_nettype none

package zx_pkg;

	// ==================================================
	// Widths and memory layout
	// ==================================================
	localparam int BANK_W     = 7;
	localparam int OFFS_W     = 14;
	localparam int RAM_ADDR_W = BANK_W + OFFS_W;
	localparam int TURBO_W    = 5;
	localparam int SPEED_W    = 3;

	// ROM pages live in their own region of the RAM
	localparam logic [2:0] ROM_REGION = 3'b101;

	// Turbo masks, one cycle more than the mask is the CPU period
	localparam logic [TURBO_W-1:0] TURBO_ORIG = 5'b11111;
	localparam logic [TURBO_W-1:0] TURBO_X2   = 5'b01111;
	localparam logic [TURBO_W-1:0] TURBO_X4   = 5'b00111;
	localparam logic [TURBO_W-1:0] TURBO_X8   = 5'b00011;
	localparam logic [TURBO_W-1:0] TURBO_X16  = 5'b00001;

	// Negative phases spent stopped after a speed change
	localparam int SWITCH_WAIT = 3;

	// Speed FSM states
	localparam logic [1:0] ST_RUNNING   = 2'd0;
	localparam logic [1:0] ST_SWITCHING = 2'd1;
	localparam logic [1:0] ST_STOPPED   = 2'd2;

	// ==================================================
	// Types
	// ==================================================
	typedef enum logic [1:0] {
		m_128,
		m_48,
		m_plus3
	} machine_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        rd;
		logic        wr;
		logic        iorq;
	} cpu_bus_t;

	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            din;
		logic                  we;
		logic                  rd;
	} mem_req_t;

	// 1FFD in normal paging mode
	typedef struct packed {
		logic [3:0] spare_hi;
		logic       motor;
		logic       rom_hi;
		logic       spare_lo;
		logic       special;
	} page_1ffd_norm_t;

	// 1FFD in all-RAM mode
	typedef struct packed {
		logic [4:0] spare;
		logic [1:0] config_mode;
		logic       special;
	} page_1ffd_spec_t;

	typedef union packed {
		page_1ffd_norm_t norm;
		page_1ffd_spec_t spec;
	} page_1ffd_u;

	typedef struct packed {
		logic [7:0] page_7ffd;
		page_1ffd_u page_1ffd;
		logic       zx48;
		logic       plus3;
		logic       page_disable;
	} page_state_t;

endpackage

`default_nettype wire
